// File: list.f
design/ppu_pkg.sv
design/ppu_dot_timer.sv
design/ppu_hphase_fsm.sv
design/sp_eval.sv
design/sprite_slot_buf.sv
design/oam_ram.sv
design/chr_mem.sv
design/sprite_eval_top.sv
tb/tb_clk_gen.sv
tb/sprite_eval_props.sv
tb/tb_sprite_eval.sv

// File: run.sh
#!/bin/sh
# compile and run the sprite evaluation testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_sprite_eval -f list.f > sim.log 2>&1 \
    && ./obj_dir/Vtb_sprite_eval >> sim.log 2>&1 \
    || echo "TESTS FAILED" >> sim.log
grep -q "^TESTS PASSED$" sim.log || echo "TESTS FAILED" >> sim.log
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

// File: tb/tb_sprite_eval.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sprite_eval;

    localparam int CLK_PERIOD  = 4;
    localparam int RESET_CLKS  = 16;
    localparam int DRIVE_DELAY = 1;
    localparam int NUM_FRAMES  = 4;
    localparam int NUM_SPRITES = 64;
    localparam int CHR_BYTES   = 8192;
    localparam int CHECK_COL   = int'(ppu_pkg::GARB_START);
    localparam int FRAME_CLKS  = (int'(ppu_pkg::LAST_ROW) + 1) * (int'(ppu_pkg::LAST_COL) + 1)
                                 * ppu_pkg::DOT_DIV;
    localparam int TIMEOUT_NS  = 5 * FRAME_CLKS * CLK_PERIOD;
    localparam logic [31:0] LFSR_SEED = 32'h34e1_02f8;

    logic                   clk;
    logic                   rst_n;
    ppu_pkg::pattern_tbl_t  patt_tbl;
    logic                   oam_wr;
    ppu_pkg::oam_addr_t     oam_wr_addr;
    logic [7:0]             oam_wr_data;
    logic                   chr_wr;
    ppu_pkg::chr_addr_t     chr_wr_addr;
    logic [7:0]             chr_wr_data;
    logic                   dot_en;
    ppu_pkg::row_t          row;
    ppu_pkg::col_t          col;
    ppu_pkg::hs_state_t     hs_state;
    ppu_pkg::second_oam_t [ppu_pkg::SLOT_COUNT-1:0] sec_slots;

    // reference copies of what the DUT memories hold
    logic [7:0]  oam_copy [256];
    logic [7:0]  chr_copy [CHR_BYTES];
    logic [31:0] lfsr_state;

    tb_clk_gen u_clk_gen (
        .clk (clk)
    );

    sprite_eval_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .patt_tbl    (patt_tbl),
        .oam_wr      (oam_wr),
        .oam_wr_addr (oam_wr_addr),
        .oam_wr_data (oam_wr_data),
        .chr_wr      (chr_wr),
        .chr_wr_addr (chr_wr_addr),
        .chr_wr_data (chr_wr_data),
        .dot_en      (dot_en),
        .row         (row),
        .col         (col),
        .hs_state    (hs_state),
        .sec_slots   (sec_slots)
    );

    bind sprite_eval_top sprite_eval_props u_props (
        .clk       (clk),
        .rst_n     (rst_n),
        .dot_en    (dot_en),
        .row       (row),
        .col       (col),
        .hs_state  (hs_state),
        .sec_wr    (sec_wr),
        .sec_slots (sec_slots)
    );

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got == exp)
            else abort_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic write_chr(input ppu_pkg::chr_addr_t addr, input logic [7:0] data);
        @(posedge clk);
        #DRIVE_DELAY;
        chr_wr         = 1'b1;
        chr_wr_addr    = addr;
        chr_wr_data    = data;
        chr_copy[addr] = data;
    endtask

    task automatic write_oam(input ppu_pkg::oam_addr_t addr, input logic [7:0] data);
        @(posedge clk);
        #DRIVE_DELAY;
        oam_wr         = 1'b1;
        oam_wr_addr    = addr;
        oam_wr_data    = data;
        oam_copy[addr] = data;
    endtask

    task automatic load_chr();
        logic [31:0] bits;
        for (int a = 0; a < CHR_BYTES; a++) begin
            take_bits(8, bits);
            write_chr(13'(a), bits[7:0]);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        chr_wr = 1'b0;
    endtask

    // bands of 3, 8 and 12 sprites, empty rows, scattered and hidden sprites
    task automatic load_scene(input int frame);
        logic [31:0] bits;
        logic [31:0] sprite;
        logic [7:0]  y;
        for (int s = 0; s < NUM_SPRITES; s++) begin
            if (s < 3) begin
                y = 8'(8 + frame);
            end else if (s < 11) begin
                y = 8'(40 + 2 * frame);
            end else if (s < 23) begin
                y = 8'(72 + 3 * frame);
            end else if (s == 23) begin
                y = 8'(76 + 3 * frame);
            end else if (s == 24) begin
                y = 8'(232 + frame);
            end else if (s < 48) begin
                take_bits(7, bits);
                y = 8'(144 + int'(bits[6:0]) % 88);
            end else begin
                take_bits(4, bits);
                y = 8'(240 + int'(bits[3:0]));
            end
            // tile, attribute with random flip, x
            take_bits(24, bits);
            sprite = {y, bits[23:0]};
            for (int b = 0; b < 4; b++) begin
                write_oam(8'(4 * s + b), sprite[31 - 8 * b -: 8]);
            end
        end
        @(posedge clk);
        #DRIVE_DELAY;
        oam_wr = 1'b0;
    endtask

    task automatic wait_dot(input int r, input int c);
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
        end while (!(row == 9'(r) && col == 9'(c)));
    endtask

    task automatic check_row(input int r);
        ppu_pkg::second_oam_t exp_slots [ppu_pkg::SLOT_COUNT];
        ppu_pkg::second_oam_t entry;
        int n;
        int y;
        int tile_row;
        int addr;
        n = 0;
        for (int i = 0; i < ppu_pkg::SLOT_COUNT; i++) begin
            exp_slots[3'(i)] = '0;
        end
        for (int s = 0; s < NUM_SPRITES; s++) begin
            y = int'(oam_copy[8'(4 * s)]);
            if (n < ppu_pkg::SLOT_COUNT && r >= y && r < y + ppu_pkg::SPRITE_HEIGHT) begin
                entry           = '0;
                entry.active    = 1'b1;
                entry.y_pos     = oam_copy[8'(4 * s)];
                entry.tile_idx  = oam_copy[8'(4 * s + 1)];
                entry.attribute = oam_copy[8'(4 * s + 2)];
                entry.x_pos     = oam_copy[8'(4 * s + 3)];
                tile_row = r - y;
                // vertical flip
                if (entry.attribute[7]) begin
                    tile_row = 7 - tile_row;
                end
                addr = (patt_tbl == ppu_pkg::RIGHT_TBL) ? 'h1000 : 'h0000;
                addr = addr + 16 * int'(entry.tile_idx) + tile_row;
                entry.bitmap_lo  = chr_copy[13'(addr)];
                entry.bitmap_hi  = chr_copy[13'(addr + 8)];
                exp_slots[3'(n)] = entry;
                n++;
            end
        end
        for (int i = 0; i < ppu_pkg::SLOT_COUNT; i++) begin
            expect_eq($sformatf("sec_slots[%0d] row %0d", i, r),
                      {15'd0, sec_slots[3'(i)]}, {15'd0, exp_slots[3'(i)]});
        end
    endtask

    initial begin
        #TIMEOUT_NS;
        abort_run("timeout: the frames did not complete in the expected time");
    end

    initial begin
        rst_n       = 1'b0;
        patt_tbl    = ppu_pkg::LEFT_TBL;
        oam_wr      = 1'b0;
        oam_wr_addr = '0;
        oam_wr_data = '0;
        chr_wr      = 1'b0;
        chr_wr_addr = '0;
        chr_wr_data = '0;
        lfsr_state  = LFSR_SEED;
        repeat (RESET_CLKS) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        // state before the first dot
        expect_eq("row", {55'd0, row}, 64'd0);
        expect_eq("col", {55'd0, col}, 64'd0);
        expect_eq("hs_state", {61'd0, hs_state}, {61'd0, ppu_pkg::SL_PRE_CYC});
        for (int i = 0; i < ppu_pkg::SLOT_COUNT; i++) begin
            expect_eq($sformatf("sec_slots[%0d].active", i),
                      {63'd0, sec_slots[3'(i)].active}, 64'd0);
        end

        // frame 0 only loads, the next frames are checked line by line
        for (int frame = 1; frame < NUM_FRAMES; frame++) begin
            wait_dot(int'(ppu_pkg::LAST_VISIBLE_ROW) + 1, 0);
            if (frame == 1) begin
                load_chr();
            end
            load_scene(frame);
            patt_tbl = (frame % 2 == 0) ? ppu_pkg::RIGHT_TBL : ppu_pkg::LEFT_TBL;
            for (int r = 0; r <= int'(ppu_pkg::LAST_VISIBLE_ROW); r++) begin
                wait_dot(r, CHECK_COL);
                check_row(r);
            end
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/sprite_eval_props.sv
`timescale 1ns/1ns
`default_nettype none

module sprite_eval_props (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     dot_en,
    input ppu_pkg::row_t            row,
    input ppu_pkg::col_t            col,
    input ppu_pkg::hs_state_t       hs_state,
    input logic                     sec_wr,
    input ppu_pkg::second_oam_t [ppu_pkg::SLOT_COUNT-1:0] sec_slots
);

    logic [1:0] clks_since_dot;

    // clocks since the last dot strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clks_since_dot <= '0;
        end else if (dot_en) begin
            clks_since_dot <= '0;
        end else begin
            clks_since_dot <= clks_since_dot + 2'd1;
        end
    end

    // phase expected for a dot position
    function automatic ppu_pkg::hs_state_t phase_at(ppu_pkg::row_t r, ppu_pkg::col_t c);
        if (r > ppu_pkg::LAST_VISIBLE_ROW) return ppu_pkg::VBL_CYC;
        if (c < ppu_pkg::IDLE_START) return ppu_pkg::SL_PRE_CYC;
        if (c == ppu_pkg::IDLE_START) return ppu_pkg::IDLE_CYC;
        if (c < ppu_pkg::GARB_START) return ppu_pkg::SP_PRE_CYC;
        if (c < ppu_pkg::TL_PRE_START) return ppu_pkg::GARB_CYC;
        return ppu_pkg::TL_PRE_CYC;
    endfunction

    a_dot_period: assert property (@(posedge clk) disable iff (!rst_n)
        dot_en == (clks_since_dot == 2'd3))
        else $error("dot strobe period is not four clocks");

    a_col_step: assert property (@(posedge clk) disable iff (!rst_n)
        dot_en && col != ppu_pkg::LAST_COL |=> col == $past(col) + 9'd1 && row == $past(row))
        else $error("column did not advance by one");

    a_line_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        dot_en && col == ppu_pkg::LAST_COL && row != ppu_pkg::LAST_ROW
        |=> col == 9'd0 && row == $past(row) + 9'd1)
        else $error("line wrap is wrong");

    a_frame_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        dot_en && col == ppu_pkg::LAST_COL && row == ppu_pkg::LAST_ROW
        |=> col == 9'd0 && row == 9'd0)
        else $error("frame wrap is wrong");

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !dot_en |=> $stable(col) && $stable(row))
        else $error("row or column moved without a dot strobe");

    a_phase: assert property (@(posedge clk) disable iff (!rst_n)
        hs_state == phase_at(row, col))
        else $error("horizontal phase does not match the dot position");

    // fetch dots of a visible line, judged from the dot position
    a_sec_wr: assert property (@(posedge clk) disable iff (!rst_n)
        sec_wr |-> row <= ppu_pkg::LAST_VISIBLE_ROW && col >= ppu_pkg::SP_PRE_START
            && col < ppu_pkg::GARB_START)
        else $error("secondary OAM write outside sprite fetch");

    // only the clear dot and the fetch dots may touch secondary OAM
    a_sec_stable: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(sec_slots) |-> $past(dot_en) &&
            ($past(hs_state) == ppu_pkg::IDLE_CYC || $past(hs_state) == ppu_pkg::SP_PRE_CYC))
        else $error("secondary OAM changed outside its update window");

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic clk
);

    localparam int HALF_PERIOD = 2;

    // 4 ns master clock
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

`default_nettype wire

// File: design/sprite_eval_top.sv
`timescale 1ns/1ns
`default_nettype none

module sprite_eval_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ppu_pkg::pattern_tbl_t   patt_tbl,
    input  logic                    oam_wr,
    input  ppu_pkg::oam_addr_t      oam_wr_addr,
    input  logic [7:0]              oam_wr_data,
    input  logic                    chr_wr,
    input  ppu_pkg::chr_addr_t      chr_wr_addr,
    input  logic [7:0]              chr_wr_data,
    output logic                    dot_en,
    output ppu_pkg::row_t           row,
    output ppu_pkg::col_t           col,
    output ppu_pkg::hs_state_t      hs_state,
    output ppu_pkg::second_oam_t [ppu_pkg::SLOT_COUNT-1:0] sec_slots
);

    ppu_pkg::oam_addr_t     oam_addr;
    logic [7:0]             oam_data;
    logic                   temp_clr;
    logic                   temp_wr;
    ppu_pkg::second_oam_t   temp_wr_data;
    ppu_pkg::slot_idx_t     temp_rd_idx;
    ppu_pkg::second_oam_t   temp_rd_data;
    logic                   sec_clr;
    logic                   sec_wr;
    ppu_pkg::second_oam_t   sec_wr_data;
    ppu_pkg::chr_addr_t     chr_addr_lo;
    ppu_pkg::chr_addr_t     chr_addr_hi;
    logic                   chr_re;
    logic [7:0]             chr_data_lo;
    logic [7:0]             chr_data_hi;

    ppu_dot_timer u_dot_timer (
        .clk    (clk),
        .rst_n  (rst_n),
        .dot_en (dot_en),
        .row    (row),
        .col    (col)
    );

    ppu_hphase_fsm u_hphase_fsm (
        .clk      (clk),
        .rst_n    (rst_n),
        .dot_en   (dot_en),
        .col      (col),
        .row      (row),
        .hs_state (hs_state)
    );

    sp_eval u_sp_eval (
        .clk          (clk),
        .rst_n        (rst_n),
        .dot_en       (dot_en),
        .row          (row),
        .col          (col),
        .hs_state     (hs_state),
        .patt_tbl     (patt_tbl),
        .oam_addr     (oam_addr),
        .oam_data     (oam_data),
        .temp_clr     (temp_clr),
        .temp_wr      (temp_wr),
        .temp_wr_data (temp_wr_data),
        .temp_rd_idx  (temp_rd_idx),
        .temp_rd_data (temp_rd_data),
        .sec_clr      (sec_clr),
        .sec_wr       (sec_wr),
        .sec_wr_data  (sec_wr_data),
        .chr_addr_lo  (chr_addr_lo),
        .chr_addr_hi  (chr_addr_hi),
        .chr_re       (chr_re),
        .chr_data_lo  (chr_data_lo),
        .chr_data_hi  (chr_data_hi)
    );

    // in-range sprites of the line being scanned
    sprite_slot_buf u_temp_oam (
        .clk     (clk),
        .rst_n   (rst_n),
        .dot_en  (dot_en),
        .clr     (temp_clr),
        .wr      (temp_wr),
        .wr_data (temp_wr_data),
        .rd_idx  (temp_rd_idx),
        .rd_data (temp_rd_data),
        .slots   ()
    );

    // finished slots with pattern bytes, filled in order
    sprite_slot_buf u_sec_oam (
        .clk     (clk),
        .rst_n   (rst_n),
        .dot_en  (dot_en),
        .clr     (sec_clr),
        .wr      (sec_wr),
        .wr_data (sec_wr_data),
        .rd_idx  (3'd0),
        .rd_data (),
        .slots   (sec_slots)
    );

    oam_ram u_oam_ram (
        .clk     (clk),
        .wr      (oam_wr),
        .wr_addr (oam_wr_addr),
        .wr_data (oam_wr_data),
        .rd_addr (oam_addr),
        .rd_data (oam_data)
    );

    chr_mem u_chr_mem (
        .clk     (clk),
        .wr      (chr_wr),
        .wr_addr (chr_wr_addr),
        .wr_data (chr_wr_data),
        .re      (chr_re),
        .addr_lo (chr_addr_lo),
        .addr_hi (chr_addr_hi),
        .data_lo (chr_data_lo),
        .data_hi (chr_data_hi)
    );

endmodule

`default_nettype wire

// File: design/chr_mem.sv
`timescale 1ns/1ns
`default_nettype none

module chr_mem (
    input  logic                clk,
    input  logic                wr,
    input  ppu_pkg::chr_addr_t  wr_addr,
    input  logic [7:0]          wr_data,
    input  logic                re,
    input  ppu_pkg::chr_addr_t  addr_lo,
    input  ppu_pkg::chr_addr_t  addr_hi,
    output logic [7:0]          data_lo,
    output logic [7:0]          data_hi
);

    // both pattern tables, 4 KiB each
    logic [7:0] mem [8192];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // low and high bit planes read in the same dot
    assign data_lo = re ? mem[addr_lo] : 8'h00;
    assign data_hi = re ? mem[addr_hi] : 8'h00;

endmodule

`default_nettype wire

// File: design/oam_ram.sv
`timescale 1ns/1ns
`default_nettype none

module oam_ram (
    input  logic                clk,
    input  logic                wr,
    input  ppu_pkg::oam_addr_t  wr_addr,
    input  logic [7:0]          wr_data,
    input  ppu_pkg::oam_addr_t  rd_addr,
    output logic [7:0]          rd_data
);

    // 64 sprites of 4 bytes
    logic [7:0] mem [256];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

// File: design/sprite_slot_buf.sv
`timescale 1ns/1ns
`default_nettype none

module sprite_slot_buf (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    dot_en,
    input  logic                    clr,
    input  logic                    wr,
    input  ppu_pkg::second_oam_t    wr_data,
    input  ppu_pkg::slot_idx_t      rd_idx,
    output ppu_pkg::second_oam_t    rd_data,
    output ppu_pkg::second_oam_t [ppu_pkg::SLOT_COUNT-1:0] slots
);

    ppu_pkg::slot_idx_t wr_ptr;
    logic               full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            full   <= 1'b0;
            slots  <= '0;
        end else if (dot_en) begin
            if (clr) begin
                wr_ptr <= '0;
                full   <= 1'b0;
                slots  <= '0;
            end else if (wr && !full) begin
                slots[wr_ptr] <= wr_data;
                wr_ptr        <= wr_ptr + 3'd1;
                // pointer wraps after the last slot, so remember it
                if (wr_ptr == 3'(ppu_pkg::SLOT_COUNT - 1)) begin
                    full <= 1'b1;
                end
            end
        end
    end

    assign rd_data = slots[rd_idx];

endmodule

`default_nettype wire

// File: design/sp_eval.sv
`timescale 1ns/1ns
`default_nettype none

module sp_eval (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    dot_en,
    input  ppu_pkg::row_t           row,
    input  ppu_pkg::col_t           col,
    input  ppu_pkg::hs_state_t      hs_state,
    input  ppu_pkg::pattern_tbl_t   patt_tbl,

    // primary OAM
    output ppu_pkg::oam_addr_t      oam_addr,
    input  logic [7:0]              oam_data,

    // temp OAM
    output logic                    temp_clr,
    output logic                    temp_wr,
    output ppu_pkg::second_oam_t    temp_wr_data,
    output ppu_pkg::slot_idx_t      temp_rd_idx,
    input  ppu_pkg::second_oam_t    temp_rd_data,

    // secondary OAM
    output logic                    sec_clr,
    output logic                    sec_wr,
    output ppu_pkg::second_oam_t    sec_wr_data,

    // character memory
    output ppu_pkg::chr_addr_t      chr_addr_lo,
    output ppu_pkg::chr_addr_t      chr_addr_hi,
    output logic                    chr_re,
    input  logic [7:0]              chr_data_lo,
    input  logic [7:0]              chr_data_hi
);

    ppu_pkg::second_oam_t   curr_sprite;
    ppu_pkg::second_oam_t   curr_sprite_in;
    ppu_pkg::row_t          y_top;
    ppu_pkg::row_t          y_end;
    logic                   in_range;
    ppu_pkg::col_t          sp_col;
    ppu_pkg::chr_addr_t     tbl_base;
    logic [2:0]             tile_row;

    // sprite being assembled, one OAM byte per dot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_sprite <= '0;
        end else if (dot_en) begin
            curr_sprite <= curr_sprite_in;
        end
    end

    // OAM scanned in step with the column
    assign oam_addr = col[7:0];

    assign y_top    = {1'b0, oam_data};
    assign y_end    = y_top + 9'(ppu_pkg::SPRITE_HEIGHT);
    assign in_range = (y_top <= row) && (row < y_end);

    assign temp_wr_data = curr_sprite_in;

    // slot fetched in each SP_PRE dot
    assign sp_col      = col - ppu_pkg::SP_PRE_START;
    assign temp_rd_idx = sp_col[2:0];

    assign tbl_base = (patt_tbl == ppu_pkg::RIGHT_TBL) ? ppu_pkg::RIGHT_TBL_BASE
                                                       : ppu_pkg::LEFT_TBL_BASE;

    // row - y_pos is 0..7 for an in-range sprite, so three bits are enough
    assign tile_row = temp_rd_data.attribute[7] ? 3'd7 - (row[2:0] - temp_rd_data.y_pos[2:0])
                                                : row[2:0] - temp_rd_data.y_pos[2:0];

    // base + 16 * tile + row, high plane 8 bytes above
    assign chr_addr_lo = tbl_base + {1'b0, temp_rd_data.tile_idx, 1'b0, tile_row};
    assign chr_addr_hi = chr_addr_lo + 13'd8;

    always_comb begin
        curr_sprite_in = '0;
        temp_clr       = 1'b0;
        temp_wr        = 1'b0;
        sec_clr        = 1'b0;
        sec_wr         = 1'b0;
        sec_wr_data    = '0;
        chr_re         = 1'b0;

        case (hs_state)
            ppu_pkg::SL_PRE_CYC: begin
                case (col[1:0])
                    2'd0: begin
                        if (in_range) begin
                            curr_sprite_in.active = 1'b1;
                            curr_sprite_in.y_pos  = oam_data;
                        end
                    end
                    2'd1: begin
                        if (curr_sprite.active) begin
                            curr_sprite_in          = curr_sprite;
                            curr_sprite_in.tile_idx = oam_data;
                        end
                    end
                    2'd2: begin
                        if (curr_sprite.active) begin
                            curr_sprite_in           = curr_sprite;
                            curr_sprite_in.attribute = oam_data;
                        end
                    end
                    default: begin
                        if (curr_sprite.active) begin
                            curr_sprite_in       = curr_sprite;
                            curr_sprite_in.x_pos = oam_data;
                            temp_wr              = 1'b1;
                        end
                    end
                endcase
            end
            ppu_pkg::IDLE_CYC: begin
                sec_clr = 1'b1;
            end
            ppu_pkg::SP_PRE_CYC: begin
                chr_re = 1'b1;
                sec_wr = 1'b1;
                // empty slots stay all zero
                if (temp_rd_data.active) begin
                    sec_wr_data           = temp_rd_data;
                    sec_wr_data.bitmap_hi = chr_data_hi;
                    sec_wr_data.bitmap_lo = chr_data_lo;
                end
            end
            ppu_pkg::GARB_CYC, ppu_pkg::TL_PRE_CYC: begin
                temp_clr = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: design/ppu_hphase_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module ppu_hphase_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                dot_en,
    input  ppu_pkg::col_t       col,
    input  ppu_pkg::row_t       row,
    output ppu_pkg::hs_state_t  hs_state
);

    ppu_pkg::hs_state_t next_state;
    logic               next_row_visible;

    // row that starts after the current line ends
    assign next_row_visible = (row < ppu_pkg::LAST_VISIBLE_ROW) ||
                              (row == ppu_pkg::LAST_ROW);

    // transitions look at the column being left, so state lines up with col
    always_comb begin
        next_state = hs_state;
        case (hs_state)
            ppu_pkg::SL_PRE_CYC: begin
                if (col == ppu_pkg::IDLE_START - 9'd1)
                    next_state = ppu_pkg::IDLE_CYC;
            end
            ppu_pkg::IDLE_CYC: begin
                next_state = ppu_pkg::SP_PRE_CYC;
            end
            ppu_pkg::SP_PRE_CYC: begin
                if (col == ppu_pkg::GARB_START - 9'd1)
                    next_state = ppu_pkg::GARB_CYC;
            end
            ppu_pkg::GARB_CYC: begin
                if (col == ppu_pkg::TL_PRE_START - 9'd1)
                    next_state = ppu_pkg::TL_PRE_CYC;
            end
            ppu_pkg::TL_PRE_CYC, ppu_pkg::VBL_CYC: begin
                if (col == ppu_pkg::LAST_COL)
                    next_state = next_row_visible ? ppu_pkg::SL_PRE_CYC : ppu_pkg::VBL_CYC;
            end
            default: next_state = ppu_pkg::SL_PRE_CYC;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_state <= ppu_pkg::SL_PRE_CYC;
        end else if (dot_en) begin
            hs_state <= next_state;
        end
    end

endmodule

`default_nettype wire

// File: design/ppu_dot_timer.sv
`timescale 1ns/1ns
`default_nettype none

module ppu_dot_timer (
    input  logic            clk,
    input  logic            rst_n,
    output logic            dot_en,
    output ppu_pkg::row_t   row,
    output ppu_pkg::col_t   col
);

    logic [1:0] presc;

    // one dot every DOT_DIV master clocks
    assign dot_en = (presc == 2'(ppu_pkg::DOT_DIV - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc <= 2'd0;
        end else begin
            presc <= presc + 2'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (dot_en) begin
            if (col == ppu_pkg::LAST_COL) begin
                col <= '0;
                // end of frame
                if (row == ppu_pkg::LAST_ROW) begin
                    row <= '0;
                end else begin
                    row <= row + 9'd1;
                end
            end else begin
                col <= col + 9'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/ppu_pkg.sv
`default_nettype none

package ppu_pkg;

    // widths with a meaning of their own
    typedef logic [8:0]  row_t;
    typedef logic [8:0]  col_t;
    typedef logic [7:0]  oam_addr_t;
    typedef logic [12:0] chr_addr_t;
    typedef logic [2:0]  slot_idx_t;

    typedef enum logic {
        LEFT_TBL,
        RIGHT_TBL
    } pattern_tbl_t;

    // horizontal phase of a line
    typedef enum logic [2:0] {
        SL_PRE_CYC,
        IDLE_CYC,
        SP_PRE_CYC,
        GARB_CYC,
        TL_PRE_CYC,
        VBL_CYC
    } hs_state_t;

    // one sprite slot, 49 bits
    typedef struct packed {
        logic       active;
        logic [7:0] y_pos;
        logic [7:0] tile_idx;
        logic [7:0] attribute;
        logic [7:0] x_pos;
        logic [7:0] bitmap_hi;
        logic [7:0] bitmap_lo;
    } second_oam_t;

    localparam int SPRITE_HEIGHT = 8;
    localparam int SLOT_COUNT    = 8;
    localparam int DOT_DIV       = 4;

    localparam col_t LAST_COL         = 9'd340;
    localparam row_t LAST_ROW         = 9'd261;
    localparam row_t LAST_VISIBLE_ROW = 9'd239;

    // first column of each phase on a visible line
    localparam col_t IDLE_START   = 9'd256;
    localparam col_t SP_PRE_START = 9'd257;
    localparam col_t GARB_START   = 9'd265;
    localparam col_t TL_PRE_START = 9'd321;

    localparam chr_addr_t LEFT_TBL_BASE  = 13'h0000;
    localparam chr_addr_t RIGHT_TBL_BASE = 13'h1000;

endpackage

`default_nettype wire
